//--- common/atax_cfg.svh
`ifndef ATAX_CFG_SVH
`define ATAX_CFG_SVH

// ##################################################
// atax kernel dimensions
// ##################################################

// matrix is N x N, x and y hold N words
`define ATAX_N          8

// A is cyclically partitioned over this many banks
`define ATAX_PART       4
`define ATAX_BANK_W     2

// 32-bit signed, wrapping
`define ATAX_DW         32

// words per A bank, N*N/PART
`define ATAX_A_DEPTH    16

// shared by A banks and the x bank
`define ATAX_AW         4

// folded signature width
`define ATAX_OUT_W      4

`endif

//--- common/atax_pkg.sv
`include "atax_cfg.svh"

package atax_pkg;

    // ##################################################
    // load port
    // ##################################################

    // which memory a load word goes to
    typedef enum logic
    {
        LOAD_A = 1'b0,
        LOAD_X = 1'b1
    } load_target_e;

    // one word written into the shadow half of a bank
    // bank is ignored for x loads
    typedef struct packed
    {
        logic                       en;
        load_target_e               target;
        logic [`ATAX_BANK_W-1:0]    bank;
        logic [`ATAX_AW-1:0]        addr;
        logic [`ATAX_DW-1:0]        data;
    } load_req_t;

    // ##################################################
    // core control
    // ##################################################

    // idle, fetch x, A*x, A^T*tmp, stream y, done pulse
    typedef enum logic [2:0]
    {
        ST_IDLE   = 3'd0,
        ST_LOAD_X = 3'd1,
        ST_MV     = 3'd2,
        ST_MTV    = 3'd3,
        ST_OUT    = 3'd4,
        ST_DONE   = 3'd5
    } core_state_e;

endpackage

//--- kernel_ram/kernel_ram.sv
`timescale 1ns/10ps
`include "atax_cfg.svh"

module kernel_ram
#(
    parameter int DEPTH = `ATAX_A_DEPTH
)
(
    input  logic                    ap_clk,
    input  logic                    arst_n,
    input  logic                    swap,
    input  logic                    wr_en,
    input  logic [`ATAX_AW-1:0]     wr_addr,
    input  logic [`ATAX_DW-1:0]     wr_data,
    input  logic                    rd_en,
    input  logic [`ATAX_AW-1:0]     rd_addr,
    output logic [`ATAX_DW-1:0]     rd_data
);

    localparam int IW = $clog2(DEPTH);

    // half the kernel reads from
    logic half;
    // half the load port writes to
    logic wr_half;

    // two datasets, indexed by half then word
    logic [`ATAX_DW-1:0] mem [2][DEPTH];

    // ##################################################
    // half select
    // ##################################################

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            half <= 1'b0;
        end
        else if (swap)
        begin
            half <= ~half;
        end
    end

    // on the swap edge the old active half becomes the new shadow,
    // so a write there already belongs to the next run
    assign wr_half = swap ? half : ~half;

    // ##################################################
    // storage
    // ##################################################

    always_ff @(posedge ap_clk)
    begin
        if (wr_en)
        begin
            mem[wr_half][wr_addr[IW-1:0]] <= wr_data;
        end
    end

    // read latency 1
    always_ff @(posedge ap_clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[half][rd_addr[IW-1:0]];
        end
    end

endmodule

//--- atax_core/atax_core.sv
`timescale 1ns/10ps
`include "atax_cfg.svh"

module atax_core
(
    input  logic                                ap_clk,
    input  logic                                arst_n,
    input  logic                                ap_start,
    output logic                                ap_done,
    output logic                                ap_idle,
    output logic                                run_start,
    output logic [`ATAX_PART-1:0]               a_rd_en,
    output logic [`ATAX_PART-1:0][`ATAX_AW-1:0] a_rd_addr,
    input  logic [`ATAX_PART-1:0][`ATAX_DW-1:0] a_rd_data,
    output logic                                x_rd_en,
    output logic [`ATAX_AW-1:0]                 x_rd_addr,
    input  logic [`ATAX_DW-1:0]                 x_rd_data,
    output logic [`ATAX_DW-1:0]                 y_din,
    output logic                                y_write
);

    localparam int CW = $clog2(`ATAX_A_DEPTH + 1);
    localparam int RW = $clog2(`ATAX_N);

    // what the read issued last cycle was for
    typedef struct packed
    {
        logic                   x_vld;
        logic                   mv_vld;
        logic                   mtv_vld;
        logic [`ATAX_AW-1:0]    idx;
    } rd_tag_t;

    atax_pkg::core_state_e  state;
    atax_pkg::core_state_e  state_nxt;
    logic [CW-1:0]          cnt;
    logic                   last;
    rd_tag_t                tag_q;
    logic [RW-1:0]          tag_row;
    logic                   tag_grp;

    logic [`ATAX_DW-1:0]    x_reg [`ATAX_N];
    logic [`ATAX_DW-1:0]    tmp   [`ATAX_N];
    logic [`ATAX_DW-1:0]    y_acc [`ATAX_N];
    logic [`ATAX_DW-1:0]    mv_sum;
    logic [`ATAX_DW-1:0]    mtv_prod [`ATAX_PART];

    // ##################################################
    // FSM
    // ##################################################

    // last cycle of each phase
    always_comb
    begin
        case (state)
            atax_pkg::ST_LOAD_X: last = (cnt == CW'(`ATAX_N));
            atax_pkg::ST_MV:     last = (cnt == CW'(`ATAX_A_DEPTH - 1));
            atax_pkg::ST_MTV:    last = (cnt == CW'(`ATAX_A_DEPTH - 1));
            atax_pkg::ST_OUT:    last = (cnt == CW'(`ATAX_N - 1));
            default:             last = 1'b1;
        endcase
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            atax_pkg::ST_IDLE:
                if (ap_start)
                    state_nxt = atax_pkg::ST_LOAD_X;
            atax_pkg::ST_LOAD_X:
                if (last)
                    state_nxt = atax_pkg::ST_MV;
            atax_pkg::ST_MV:
                if (last)
                    state_nxt = atax_pkg::ST_MTV;
            atax_pkg::ST_MTV:
                if (last)
                    state_nxt = atax_pkg::ST_OUT;
            atax_pkg::ST_OUT:
                if (last)
                    state_nxt = atax_pkg::ST_DONE;
            default:
                state_nxt = atax_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= atax_pkg::ST_IDLE;
            cnt   <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state != state_nxt)
                cnt <= '0;
            else if (state != atax_pkg::ST_IDLE)
                cnt <= cnt + 1'b1;
        end
    end

    assign run_start = (state == atax_pkg::ST_IDLE) && ap_start;
    assign ap_idle   = (state == atax_pkg::ST_IDLE);
    assign ap_done   = (state == atax_pkg::ST_DONE);

    // ##################################################
    // read issue
    // ##################################################

    // x word j at address j, one per cycle
    assign x_rd_en   = (state == atax_pkg::ST_LOAD_X) && (cnt < CW'(`ATAX_N));
    assign x_rd_addr = cnt[`ATAX_AW-1:0];

    // address i*2 + g gives A[i][g*4 + b] from bank b, both matrix passes
    always_comb
    begin
        for (int b = 0; b < `ATAX_PART; b++)
        begin
            a_rd_en[b]   = (state == atax_pkg::ST_MV) || (state == atax_pkg::ST_MTV);
            a_rd_addr[b] = cnt[`ATAX_AW-1:0];
        end
    end

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tag_q <= '0;
        end
        else
        begin
            tag_q.x_vld   <= x_rd_en;
            tag_q.mv_vld  <= (state == atax_pkg::ST_MV);
            tag_q.mtv_vld <= (state == atax_pkg::ST_MTV);
            tag_q.idx     <= cnt[`ATAX_AW-1:0];
        end
    end

    assign tag_row = tag_q.idx[`ATAX_AW-1:1];
    assign tag_grp = tag_q.idx[0];

    // ##################################################
    // datapath
    // ##################################################

    // tmp[i] += four products of row i, low 32 bits only
    always_comb
    begin
        mv_sum = tmp[tag_row];
        for (int b = 0; b < `ATAX_PART; b++)
            mv_sum = mv_sum + a_rd_data[b] * x_reg[tag_grp * `ATAX_PART + b];
    end

    // A[i][j] * tmp[i] for the four columns of this group
    always_comb
    begin
        for (int b = 0; b < `ATAX_PART; b++)
            mtv_prod[b] = a_rd_data[b] * tmp[tag_row];
    end

    always_ff @(posedge ap_clk)
    begin
        if (tag_q.x_vld)
            x_reg[tag_q.idx[RW-1:0]] <= x_rd_data;

        if (run_start)
        begin
            for (int i = 0; i < `ATAX_N; i++)
            begin
                tmp[i]   <= '0;
                y_acc[i] <= '0;
            end
        end
        else
        begin
            if (tag_q.mv_vld)
                tmp[tag_row] <= mv_sum;
            if (tag_q.mtv_vld)
            begin
                for (int b = 0; b < `ATAX_PART; b++)
                begin
                    y_acc[tag_grp * `ATAX_PART + b] <=
                        y_acc[tag_grp * `ATAX_PART + b] + mtv_prod[b];
                end
            end
        end
    end

    // ##################################################
    // result stream
    // ##################################################

    // the last column group settles in OUT cycle 0, well before y[4] leaves
    assign y_write = (state == atax_pkg::ST_OUT);
    assign y_din   = y_acc[cnt[RW-1:0]];

endmodule

//--- design/atax_wrapper.sv
`timescale 1ns/10ps
`include "atax_cfg.svh"

module atax_wrapper
(
    input  logic                    ap_clk,
    input  logic                    arst_n,
    input  logic                    ap_start,
    input  atax_pkg::load_req_t     load,
    output logic                    ap_done,
    output logic                    ap_idle,
    output logic [`ATAX_OUT_W-1:0]  data_out,
    output logic                    data_valid
);

    // first fold stage, byte xor plus its valid
    typedef struct packed
    {
        logic       vld;
        logic [7:0] bx;
    } fold_t;

    logic                                   run_start;
    logic [`ATAX_PART-1:0]                  a_wr_en;
    logic                                   x_wr_en;
    logic [`ATAX_PART-1:0]                  a_rd_en;
    logic [`ATAX_PART-1:0][`ATAX_AW-1:0]    a_rd_addr;
    logic [`ATAX_PART-1:0][`ATAX_DW-1:0]    a_rd_data;
    logic                                   x_rd_en;
    logic [`ATAX_AW-1:0]                    x_rd_addr;
    logic [`ATAX_DW-1:0]                    x_rd_data;
    logic [`ATAX_DW-1:0]                    y_din;
    logic                                   y_write;
    logic [7:0]                             byte_xor;
    fold_t                                  fold_q;

    // ##################################################
    // load decode
    // ##################################################

    always_comb
    begin
        for (int b = 0; b < `ATAX_PART; b++)
        begin
            a_wr_en[b] = load.en && (load.target == atax_pkg::LOAD_A)
                         && (load.bank == `ATAX_BANK_W'(b));
        end
        x_wr_en = load.en && (load.target == atax_pkg::LOAD_X);
    end

    // ##################################################
    // banks
    // ##################################################

    for (genvar b = 0; b < `ATAX_PART; b++)
    begin : g_a_bank
        kernel_ram #(.DEPTH(`ATAX_A_DEPTH)) i_a_ram
        (
            .ap_clk  (ap_clk),
            .arst_n  (arst_n),
            .swap    (run_start),
            .wr_en   (a_wr_en[b]),
            .wr_addr (load.addr),
            .wr_data (load.data),
            .rd_en   (a_rd_en[b]),
            .rd_addr (a_rd_addr[b]),
            .rd_data (a_rd_data[b])
        );
    end

    kernel_ram #(.DEPTH(`ATAX_N)) i_x_ram
    (
        .ap_clk  (ap_clk),
        .arst_n  (arst_n),
        .swap    (run_start),
        .wr_en   (x_wr_en),
        .wr_addr (load.addr),
        .wr_data (load.data),
        .rd_en   (x_rd_en),
        .rd_addr (x_rd_addr),
        .rd_data (x_rd_data)
    );

    atax_core i_core
    (
        .ap_clk    (ap_clk),
        .arst_n    (arst_n),
        .ap_start  (ap_start),
        .ap_done   (ap_done),
        .ap_idle   (ap_idle),
        .run_start (run_start),
        .a_rd_en   (a_rd_en),
        .a_rd_addr (a_rd_addr),
        .a_rd_data (a_rd_data),
        .x_rd_en   (x_rd_en),
        .x_rd_addr (x_rd_addr),
        .x_rd_data (x_rd_data),
        .y_din     (y_din),
        .y_write   (y_write)
    );

    // ##################################################
    // result fold
    // ##################################################

    always_comb
    begin
        byte_xor = '0;
        for (int i = 0; i < `ATAX_DW / 8; i++)
            byte_xor = byte_xor ^ y_din[i*8 +: 8];
    end

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fold_q <= '0;
        end
        else
        begin
            fold_q.vld <= y_write;
            fold_q.bx  <= byte_xor;
        end
    end

    // nibble xor, zero outside valid cycles
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            data_valid <= 1'b0;
            data_out   <= '0;
        end
        else
        begin
            data_valid <= fold_q.vld;
            data_out   <= fold_q.vld ? (fold_q.bx[7:4] ^ fold_q.bx[3:0]) : '0;
        end
    end

endmodule

//--- dv/atax_tb.sv
`timescale 1ns/10ps
`include "atax_cfg.svh"

module atax_tb;

    localparam int TIMEOUT = 500;

    typedef logic [`ATAX_N-1:0][`ATAX_DW-1:0] vec_t;
    typedef logic [`ATAX_N-1:0][`ATAX_N-1:0][`ATAX_DW-1:0] mat_t;

    logic                       ap_clk;
    logic                       arst_n;
    logic                       ap_start;
    atax_pkg::load_req_t        load;
    logic                       ap_done;
    logic                       ap_idle;
    logic [`ATAX_OUT_W-1:0]     data_out;
    logic                       data_valid;

    // both halves of every bank as whole matrices
    mat_t a_model [2];
    vec_t x_model [2];
    int   model_half = 0;

    logic [`ATAX_OUT_W-1:0] exp_q [$];
    logic [`ATAX_OUT_W-1:0] got_q [$];
    logic [`ATAX_OUT_W-1:0] got_sig;
    logic [`ATAX_OUT_W-1:0] exp_sig;
    vec_t y_exp;

    int res_cnt = 0;
    int done_cnt = 0;
    int accept_cnt = 0;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    int   err_base;
    int   done_base;
    int   res_base;
    int   acc_base;
    mat_t a1;
    mat_t a2;
    vec_t x1;
    vec_t x2;

    atax_wrapper i_dut
    (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .ap_start   (ap_start),
        .load       (load),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    initial
    begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ##################################################
    // reference model
    // ##################################################

    // tmp = A*x then y = A^T*tmp with 32-bit wrapping sums
    function automatic vec_t ref_atax(input mat_t a, input vec_t x);
        vec_t tmp;
        vec_t y;
        tmp = '0;
        y   = '0;
        for (int i = 0; i < `ATAX_N; i++)
            for (int j = 0; j < `ATAX_N; j++)
                tmp[i] = tmp[i] + a[i][j] * x[j];
        for (int i = 0; i < `ATAX_N; i++)
            for (int j = 0; j < `ATAX_N; j++)
                y[j] = y[j] + a[i][j] * tmp[i];
        return y;
    endfunction

    // four bytes down to one, then two nibbles down to one
    function automatic logic [`ATAX_OUT_W-1:0] ref_fold(input logic [`ATAX_DW-1:0] w);
        logic [7:0] b;
        b = w[31:24] ^ w[23:16] ^ w[15:8] ^ w[7:0];
        return b[7:4] ^ b[3:0];
    endfunction

    // full 32-bit range so products overflow
    function automatic mat_t rand_mat();
        mat_t m;
        for (int i = 0; i < `ATAX_N; i++)
            for (int j = 0; j < `ATAX_N; j++)
                m[i][j] = $urandom();
        return m;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int j = 0; j < `ATAX_N; j++)
            v[j] = $urandom();
        return v;
    endfunction

    // ##################################################
    // run tracking, monitor, checker
    // ##################################################

    // an accepted start makes the shadow half the active one
    always @(posedge ap_clk)
    begin
        if (arst_n && ap_idle && ap_start)
        begin
            model_half = 1 - model_half;
            accept_cnt++;
            y_exp = ref_atax(a_model[model_half], x_model[model_half]);
            for (int k = 0; k < `ATAX_N; k++)
                exp_q.push_back(ref_fold(y_exp[k]));
        end
    end

    always @(posedge ap_clk)
    begin
        if (arst_n)
        begin
            if (data_valid === 1'b1)
            begin
                got_q.push_back(data_out);
                res_cnt++;
            end
            else
            begin
                assert (data_out === '0)
                else
                begin
                    $display("FAILED data_out: expected %h, got %h", 4'h0, data_out);
                    errors++;
                end
            end
            if (ap_done === 1'b1)
                done_cnt++;
        end
    end

    always @(negedge ap_clk)
    begin
        while (got_q.size() != 0)
        begin
            got_sig = got_q.pop_front();
            assert (exp_q.size() != 0)
            else
            begin
                $display("result %h arrived while no result was expected", got_sig);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                exp_sig = exp_q.pop_front();
                assert (got_sig === exp_sig)
                else
                begin
                    $display("FAILED data_out: expected %h, got %h", exp_sig, got_sig);
                    errors++;
                end
            end
        end
    end

    // ##################################################
    // driver tasks
    // ##################################################

    task automatic step();
        @(posedge ap_clk);
        #1;
    endtask

    // A[i][j] goes to bank j mod 4 at address i*2 + j/4
    task automatic load_a(input mat_t m);
        int sh;
        sh = 1 - model_half;
        for (int i = 0; i < `ATAX_N; i++)
        begin
            for (int j = 0; j < `ATAX_N; j++)
            begin
                load.en     = 1'b1;
                load.target = atax_pkg::LOAD_A;
                load.bank   = `ATAX_BANK_W'(j % `ATAX_PART);
                load.addr   = `ATAX_AW'(i * (`ATAX_N / `ATAX_PART) + j / `ATAX_PART);
                load.data   = m[i][j];
                step();
            end
        end
        load = '0;
        a_model[sh] = m;
    endtask

    task automatic load_x(input vec_t v);
        int sh;
        sh = 1 - model_half;
        for (int j = 0; j < `ATAX_N; j++)
        begin
            load.en     = 1'b1;
            load.target = atax_pkg::LOAD_X;
            load.bank   = '0;
            load.addr   = `ATAX_AW'(j);
            load.data   = v[j];
            step();
        end
        load = '0;
        x_model[sh] = v;
    endtask

    task automatic start_run();
        int t;
        t = 0;
        ap_start = 1'b1;
        step();
        while (ap_idle && t < TIMEOUT)
        begin
            step();
            t++;
        end
        if (ap_idle)
        begin
            $display("start was not accepted within %0d cycles", TIMEOUT);
            errors++;
        end
        ap_start = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int t;
        t = 0;
        while (done_cnt < target && t < TIMEOUT)
        begin
            step();
            t++;
        end
        if (done_cnt < target)
        begin
            $display("timed out waiting for ap_done after %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    // wait for the tail of the fold pipeline, then look for extras
    task automatic wait_results(input int target);
        int t;
        t = 0;
        while (res_cnt < target && t < TIMEOUT)
        begin
            step();
            t++;
        end
        if (res_cnt < target)
        begin
            $display("timed out waiting for data_valid after %0d cycles", TIMEOUT);
            errors++;
        end
        repeat (4) step();
        assert (res_cnt == target)
        else
        begin
            $display("FAILED res_cnt: expected %h, got %h", target, res_cnt);
            errors++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            $display("%0d expected results never arrived", exp_q.size());
            errors++;
        end
    endtask

    task automatic single_run();
        done_base = done_cnt;
        res_base  = res_cnt;
        start_run();
        wait_done(done_base + 1);
        wait_results(res_base + `ATAX_N);
        assert (done_cnt == done_base + 1)
        else
        begin
            $display("FAILED done_cnt: expected %h, got %h", done_base + 1, done_cnt);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    // ##################################################
    // test sequence
    // ##################################################

    initial
    begin
        void'($urandom(10));
        arst_n   = 1'b0;
        ap_start = 1'b0;
        load     = '0;
        repeat (10) @(posedge ap_clk);
        #1;
        arst_n = 1'b1;

        err_base = errors;
        assert (ap_idle === 1'b1)
        else
        begin
            $display("FAILED ap_idle: expected %h, got %h", 1'b1, ap_idle);
            errors++;
        end
        repeat (20)
        begin
            step();
            assert (ap_done === 1'b0 && data_valid === 1'b0)
            else
            begin
                $display("FAILED ap_done/data_valid: expected %h, got %h", 2'b00,
                         {ap_done, data_valid});
                errors++;
            end
        end
        report_test("reset state", err_base);

        // identity matrix gives y = x
        err_base = errors;
        a1 = '0;
        for (int i = 0; i < `ATAX_N; i++)
            a1[i][i] = 32'd1;
        for (int j = 0; j < `ATAX_N; j++)
            x1[j] = j + 1;
        load_a(a1);
        load_x(x1);
        single_run();
        report_test("identity", err_base);

        err_base = errors;
        load_a(rand_mat());
        load_x(rand_vec());
        single_run();
        report_test("random data", err_base);

        // second dataset streams in while the first run is busy
        err_base = errors;
        a1 = rand_mat();
        x1 = rand_vec();
        a2 = rand_mat();
        x2 = rand_vec();
        load_a(a1);
        load_x(x1);
        done_base = done_cnt;
        res_base  = res_cnt;
        start_run();
        load_a(a2);
        load_x(x2);
        wait_done(done_base + 1);
        wait_results(res_base + `ATAX_N);
        single_run();
        report_test("ping-pong isolation", err_base);

        // start held high for three runs over alternating halves
        err_base  = errors;
        done_base = done_cnt;
        res_base  = res_cnt;
        acc_base  = accept_cnt;
        ap_start  = 1'b1;
        wait_done(done_base + 3);
        ap_start = 1'b0;
        wait_results(res_base + 3 * `ATAX_N);
        assert (accept_cnt == acc_base + 3)
        else
        begin
            $display("FAILED accept_cnt: expected %h, got %h", acc_base + 3, accept_cnt);
            errors++;
        end
        report_test("back-to-back runs", err_base);

        // only x is rewritten so the shadow A keeps the older matrix
        err_base = errors;
        load_x(rand_vec());
        single_run();
        report_test("partial reload", err_base);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+common
common/atax_pkg.sv
kernel_ram/kernel_ram.sv
atax_core/atax_core.sv
design/atax_wrapper.sv
dv/atax_tb.sv

//--- Bender.yml
package:
  name: atax

sources:
  # synthesizable design
  - include_dirs:
      - common
    files:
      - common/atax_pkg.sv
      - kernel_ram/kernel_ram.sv
      - atax_core/atax_core.sv
      - design/atax_wrapper.sv

  # simulation only
  - target: test
    include_dirs:
      - common
    files:
      - dv/atax_tb.sv
